// File: pattern_gen_top.f
+incdir+source
source/pattern_gen_pkg.sv
source/spi_cmd_peripheral.sv
source/control_registers.sv
source/waveform_memory.sv
source/playback_sequencer.sv
source/frequency_counter.sv
source/pattern_gen_top.sv
verif/pattern_gen_chk.sv
verif/pattern_gen_tb.sv

// File: source/control_registers.sv
`include "pattern_gen_consts.svh"

module control_registers (
	input logic word_clock,
	input logic reset4_word_clock,
	input pattern_gen_pkg::spi_txn_t txn,
	output logic [`DATA_W-1:0] read_data,
	input logic [`DATA_W-1:0] freq_count,
	output logic [`BYTE_ADDR_W-1:0] start_addr,
	output logic [`BYTE_ADDR_W-1:0] end_addr,
	output logic play_enable
);

	import pattern_gen_pkg::*;

	// zero padding for the address registers on read
	localparam int pad_w = `DATA_W - `BYTE_ADDR_W;

	reg_index_t index;
	logic [`DATA_W-1:0] control_q;

	// only the low nibble of the spi address decodes
	assign index = txn.address[$bits(reg_index_t)-1:0];

	// ------------------------------------------------------------------------
	// write decode
	// ------------------------------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			start_addr <= '0;
			end_addr <= '0;
			control_q <= '0;
		end else if (txn.write) begin
			case (index)
				`REG_START: start_addr <= txn.data[`BYTE_ADDR_W-1:0];
				`REG_END: end_addr <= txn.data[`BYTE_ADDR_W-1:0];
				`REG_CONTROL: control_q <= txn.data;
				// freq register is read only, other indices unused
				default: control_q <= control_q;
			endcase
		end
	end

	// bit 0 of the control word runs playback
	assign play_enable = control_q[0];

	// ------------------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------------------
	// one cycle after the address shows up
	always_ff @(posedge word_clock) begin
		case (index)
			`REG_START: read_data <= {{pad_w{1'b0}}, start_addr};
			`REG_END: read_data <= {{pad_w{1'b0}}, end_addr};
			`REG_CONTROL: read_data <= control_q;
			`REG_FREQ: read_data <= freq_count;
			default: read_data <= '0;
		endcase
	end

endmodule

// File: source/frequency_counter.sv
`include "pattern_gen_consts.svh"

module frequency_counter (
	input logic word_clock,
	input logic reset4_word_clock,
	input logic test_clock,
	output logic [`DATA_W-1:0] freq_count
);

	logic [2:0] test_sync;
	logic test_rise;
	logic [`GATE_LOG2-1:0] gate_timer;
	logic gate_end;
	logic [`DATA_W-1:0] edge_count;

	// ------------------------------------------------------------------------
	// test clock sampling
	// ------------------------------------------------------------------------
	// two flops for metastability, third for the edge
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock)
			test_sync <= '0;
		else
			test_sync <= {test_sync[1:0], test_clock};
	end

	assign test_rise = test_sync[1] & ~test_sync[2];

	// ------------------------------------------------------------------------
	// gate window and edge count
	// ------------------------------------------------------------------------
	// last cycle of the window
	assign gate_end = &gate_timer;

	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			gate_timer <= '0;
			edge_count <= '0;
			freq_count <= '0;
		end else begin
			gate_timer <= gate_timer + 1'b1;
			if (gate_end) begin
				// publish, including an edge in this cycle
				freq_count <= edge_count + {{(`DATA_W-1){1'b0}}, test_rise};
				edge_count <= '0;
			end else if (test_rise) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

endmodule

// File: source/pattern_gen_consts.svh
`ifndef PATTERN_GEN_CONSTS_SVH
`define PATTERN_GEN_CONSTS_SVH

// ------------------------------------------------------------------------
// spi frame fields
// ------------------------------------------------------------------------
`define ADDR_W 16
`define DATA_W 32
`define CMD_W 8

// only this command code writes, anything else is a read
`define CMD_WRITE 8'h01

// ------------------------------------------------------------------------
// waveform store and playback
// ------------------------------------------------------------------------
`define WAVE_WORDS 1024
`define BYTE_ADDR_W 12

// register bank indices behind chip select 0
`define REG_START 4'd0
`define REG_END 4'd1
`define REG_CONTROL 4'd2
`define REG_FREQ 4'd15

// gate window of 2**GATE_LOG2 word_clock cycles
`define GATE_LOG2 10

`endif

// File: source/pattern_gen_pkg.sv
`include "pattern_gen_consts.svh"

package pattern_gen_pkg;

	// ------------------------------------------------------------------------
	// one decoded spi frame
	// ------------------------------------------------------------------------
	// command, address and data as seen on the wire
	// write is a single cycle pulse after the frame closes
	typedef struct packed {
		logic [`CMD_W-1:0] command;
		logic [`ADDR_W-1:0] address;
		logic [`DATA_W-1:0] data;
		logic write;
	} spi_txn_t;

	// ------------------------------------------------------------------------
	// waveform word
	// ------------------------------------------------------------------------
	// whole word for the spi side
	// byte lanes for playback, lane 3 leaves first
	typedef union packed {
		logic [`DATA_W-1:0] word;
		logic [`DATA_W/8-1:0][7:0] lanes;
	} data_word_u;

	// low address bits select a control register
	typedef logic [3:0] reg_index_t;

endpackage

// File: source/pattern_gen_top.sv
`include "pattern_gen_consts.svh"

module pattern_gen_top (
	input logic word_clock,
	input logic reset4_word_clock,
	input logic sclk,
	input logic mosi,
	input logic ssel0,
	input logic ssel1,
	input logic test_clock,
	output logic miso,
	output logic ready,
	output logic frame_sync,
	output logic [7:0] sample_word
);

	import pattern_gen_pkg::*;

	spi_txn_t reg_txn;
	spi_txn_t wave_txn;
	logic miso_regs;
	logic miso_wave;
	logic [`DATA_W-1:0] reg_read_data;
	logic [`DATA_W-1:0] wave_read_data;
	logic [`DATA_W-1:0] freq_count;
	logic [`BYTE_ADDR_W-1:0] start_addr;
	logic [`BYTE_ADDR_W-1:0] end_addr;
	logic [`BYTE_ADDR_W-1:0] play_addr;
	logic play_enable;

	// ------------------------------------------------------------------------
	// spi side, cs0 registers, cs1 waveform memory
	// ------------------------------------------------------------------------
	spi_cmd_peripheral spi_regs (.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.sclk(sclk), .mosi(mosi), .ssel(ssel0), .miso(miso_regs),
		.txn(reg_txn), .read_data(reg_read_data));

	spi_cmd_peripheral spi_wave (.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.sclk(sclk), .mosi(mosi), .ssel(ssel1), .miso(miso_wave),
		.txn(wave_txn), .read_data(wave_read_data));

	// whichever chip select is low drives miso
	assign miso = !ssel0 ? miso_regs : (!ssel1 ? miso_wave : 1'b0);

	control_registers regs (.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.txn(reg_txn), .read_data(reg_read_data), .freq_count(freq_count),
		.start_addr(start_addr), .end_addr(end_addr), .play_enable(play_enable));

	waveform_memory wave (.word_clock(word_clock), .txn(wave_txn), .read_data(wave_read_data),
		.play_addr(play_addr), .sample_word(sample_word));

	// ------------------------------------------------------------------------
	// playback and measurement
	// ------------------------------------------------------------------------
	playback_sequencer seq (.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.play_enable(play_enable), .start_addr(start_addr), .end_addr(end_addr),
		.play_addr(play_addr), .frame_sync(frame_sync));

	frequency_counter freq (.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.test_clock(test_clock), .freq_count(freq_count));

	// ready one cycle after reset drops
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock)
			ready <= 1'b0;
		else
			ready <= 1'b1;
	end

endmodule

// File: source/playback_sequencer.sv
`include "pattern_gen_consts.svh"

module playback_sequencer (
	input logic word_clock,
	input logic reset4_word_clock,
	input logic play_enable,
	input logic [`BYTE_ADDR_W-1:0] start_addr,
	input logic [`BYTE_ADDR_W-1:0] end_addr,
	output logic [`BYTE_ADDR_W-1:0] play_addr,
	output logic frame_sync
);

	// one extra bit so the last address never wraps
	logic [`BYTE_ADDR_W:0] next_addr;
	logic running;
	logic at_start;
	logic [1:0] sync_pipe;

	assign next_addr = {1'b0, play_addr} + 1'b1;

	// ------------------------------------------------------------------------
	// byte address counter
	// ------------------------------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock || !play_enable) begin
			// idle, park on the start byte
			play_addr <= start_addr;
			running <= 1'b0;
			at_start <= 1'b0;
		end else if (!running) begin
			// first loop after enable
			play_addr <= start_addr;
			running <= 1'b1;
			at_start <= 1'b1;
		end else if (next_addr >= {1'b0, end_addr}) begin
			// end minus one reached, loop back
			play_addr <= start_addr;
			at_start <= 1'b1;
		end else begin
			play_addr <= next_addr[`BYTE_ADDR_W-1:0];
			at_start <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// frame sync pipeline
	// ------------------------------------------------------------------------
	// at_start marks play_addr == start
	// two more stages match the memory read path
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock)
			sync_pipe <= '0;
		else
			sync_pipe <= {sync_pipe[0], at_start};
	end

	assign frame_sync = sync_pipe[1];

endmodule

// File: source/spi_cmd_peripheral.sv
`include "pattern_gen_consts.svh"

module spi_cmd_peripheral (
	input logic word_clock,
	input logic reset4_word_clock,
	input logic sclk,
	input logic mosi,
	input logic ssel,
	output logic miso,
	output pattern_gen_pkg::spi_txn_t txn,
	input logic [`DATA_W-1:0] read_data
);

	// fsm encodings
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_header = 2'd1;
	localparam logic [1:0] st_data = 2'd2;
	localparam logic [1:0] st_done = 2'd3;

	// 24 header bits, 56 in the whole frame
	localparam logic [5:0] header_bits = 6'(`CMD_W + `ADDR_W);
	localparam logic [5:0] frame_bits = 6'(`CMD_W + `ADDR_W + `DATA_W);

	logic [2:0] sclk_sync;
	logic [2:0] ssel_sync;
	logic [1:0] mosi_sync;
	logic sclk_rise;
	logic sclk_fall;
	logic ssel_fall;
	logic ssel_rise;

	logic [1:0] state;
	logic [5:0] bit_count;
	logic [`DATA_W-1:0] shift_in;
	logic [`DATA_W-1:0] shift_next;
	logic [`DATA_W-1:0] shift_out;
	logic shift_en;
	logic header_capture;
	logic data_capture;

	logic [`CMD_W-1:0] cmd_q;
	logic [`ADDR_W-1:0] addr_q;
	logic [`DATA_W-1:0] data_q;
	logic write_q;

	// ------------------------------------------------------------------------
	// input synchronizers and edge detect
	// ------------------------------------------------------------------------
	// chip select idles high, so the sync chain starts high
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			sclk_sync <= '0;
			ssel_sync <= '1;
			mosi_sync <= '0;
		end else begin
			sclk_sync <= {sclk_sync[1:0], sclk};
			ssel_sync <= {ssel_sync[1:0], ssel};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	// mosi_sync[1] lines up with sclk_sync[1]
	assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
	assign ssel_fall = ~ssel_sync[1] & ssel_sync[2];
	assign ssel_rise = ssel_sync[1] & ~ssel_sync[2];

	// ------------------------------------------------------------------------
	// receive shifter
	// ------------------------------------------------------------------------
	assign shift_next = {shift_in[`DATA_W-2:0], mosi_sync[1]};

	// header bits, then data bits, msb first
	assign shift_en = sclk_rise &&
		((state == st_header && bit_count < header_bits) || state == st_data);
	// last header bit and last data bit
	assign header_capture = sclk_rise && state == st_header &&
		bit_count == header_bits - 6'd1;
	assign data_capture = sclk_rise && state == st_data &&
		bit_count == frame_bits - 6'd1;

	always_ff @(posedge word_clock) begin
		if (shift_en)
			shift_in <= shift_next;
		// address goes out early so read data can be fetched
		if (header_capture) begin
			cmd_q <= shift_next[`ADDR_W +: `CMD_W];
			addr_q <= shift_next[`ADDR_W-1:0];
		end
		if (data_capture)
			data_q <= shift_next;
	end

	// ------------------------------------------------------------------------
	// frame fsm, miso shifter, write pulse
	// ------------------------------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			state <= st_idle;
			bit_count <= '0;
			shift_out <= '0;
			write_q <= 1'b0;
		end else begin
			write_q <= 1'b0;
			if (ssel_fall) begin
				// new frame
				state <= st_header;
				bit_count <= '0;
			end else if (ssel_rise) begin
				// frame closed, write only after a complete frame
				if (state == st_done && cmd_q == `CMD_WRITE)
					write_q <= 1'b1;
				state <= st_idle;
				shift_out <= '0;
			end else begin
				case (state)
					st_header: begin
						if (sclk_rise && bit_count < header_bits) begin
							bit_count <= bit_count + 6'd1;
						end else if (sclk_fall && bit_count == header_bits) begin
							// first falling edge after bit 24, read data is ready
							shift_out <= read_data;
							state <= st_data;
						end
					end
					st_data: begin
						if (sclk_rise) begin
							bit_count <= bit_count + 6'd1;
							if (bit_count == frame_bits - 6'd1)
								state <= st_done;
						end else if (sclk_fall) begin
							// host samples on the rising edge
							shift_out <= {shift_out[`DATA_W-2:0], 1'b0};
						end
					end
					// wait for chip select to go high
					st_done: begin
						bit_count <= bit_count;
					end
					default: begin
						bit_count <= '0;
					end
				endcase
			end
		end
	end

	assign miso = shift_out[`DATA_W-1];

	assign txn = '{command: cmd_q, address: addr_q, data: data_q, write: write_q};

endmodule

// File: source/waveform_memory.sv
`include "pattern_gen_consts.svh"

module waveform_memory (
	input logic word_clock,
	input pattern_gen_pkg::spi_txn_t txn,
	output logic [`DATA_W-1:0] read_data,
	input logic [`BYTE_ADDR_W-1:0] play_addr,
	output logic [7:0] sample_word
);

	import pattern_gen_pkg::*;

	localparam int word_addr_w = $clog2(`WAVE_WORDS);

	data_word_u mem [`WAVE_WORDS];

	logic [word_addr_w-1:0] spi_word_addr;
	logic [word_addr_w-1:0] play_word_addr;
	data_word_u play_word;
	logic [1:0] play_lane;

	// word index from the spi address, bits 9 to 0
	assign spi_word_addr = txn.address[word_addr_w-1:0];
	// byte address splits into word and lane
	assign play_word_addr = play_addr[`BYTE_ADDR_W-1:2];

	// ------------------------------------------------------------------------
	// spi port, whole words
	// ------------------------------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (txn.write)
			mem[spi_word_addr].word <= txn.data;
		read_data <= mem[spi_word_addr].word;
	end

	// ------------------------------------------------------------------------
	// playback port, one byte per cycle
	// ------------------------------------------------------------------------
	// stage 1 fetches the word and keeps the lane
	always_ff @(posedge word_clock) begin
		play_word <= mem[play_word_addr];
		play_lane <= play_addr[1:0];
	end

	// stage 2 picks the lane
	// byte 0 of a word is lane 3, the msb
	always_ff @(posedge word_clock) begin
		sample_word <= play_word.lanes[2'd3 - play_lane];
	end

endmodule

// File: verif/pattern_gen_chk.sv
`include "pattern_gen_consts.svh"

module pattern_gen_chk (
	input logic word_clock,
	input logic reset4_word_clock,
	input logic ready,
	input logic frame_sync,
	input logic miso,
	input logic play_enable,
	input logic [`BYTE_ADDR_W-1:0] start_addr,
	input logic [`BYTE_ADDR_W-1:0] end_addr
);

	timeunit 1ns;
	timeprecision 100ps;

	// failed assertions so far, the testbench adds these to its own errors
	int fail_count = 0;

	int sync_gap;
	int loop_len;
	logic sync_seen;

	// one loop in cycles
	assign loop_len = int'(end_addr) - int'(start_addr);

	// ------------------------------------------------------------------------
	// cycles since the previous frame sync
	// ------------------------------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock || !play_enable) begin
			sync_gap <= 0;
			sync_seen <= 1'b0;
		end else if (frame_sync) begin
			sync_gap <= 1;
			sync_seen <= 1'b1;
		end else begin
			sync_gap <= sync_gap + 1;
		end
	end

	// ------------------------------------------------------------------------
	// port properties
	// ------------------------------------------------------------------------
	// outputs quiet once reset has been seen for a cycle
	reset_quiet: assert property (@(posedge word_clock)
		reset4_word_clock ##1 reset4_word_clock |-> !frame_sync && !ready && !miso)
	else begin
		$error("frame_sync, ready or miso high during reset");
		fail_count++;
	end

	// ready one cycle after reset falls
	ready_rise: assert property (@(posedge word_clock)
		$fell(reset4_word_clock) |-> !ready ##1 ready)
	else begin
		$error("ready did not rise one cycle after reset");
		fail_count++;
	end

	// and it stays up
	ready_hold: assert property (@(posedge word_clock) disable iff (reset4_word_clock)
		ready |=> ready)
	else begin
		$error("ready dropped outside reset");
		fail_count++;
	end

	// second sync onwards, spacing is end minus start
	sync_spacing: assert property (@(posedge word_clock)
		disable iff (reset4_word_clock || !play_enable)
		frame_sync && sync_seen |-> sync_gap == loop_len)
	else begin
		$error("frame_sync spacing %0d, loop length %0d", sync_gap, loop_len);
		fail_count++;
	end

	// four cycles covers the sequencer and the two sync stages
	idle_no_sync: assert property (@(posedge word_clock) disable iff (reset4_word_clock)
		!play_enable [*4] |-> !frame_sync)
	else begin
		$error("frame_sync high while playback is disabled");
		fail_count++;
	end

endmodule

// attach to the top level
bind pattern_gen_top pattern_gen_chk chk (
	.word_clock(word_clock),
	.reset4_word_clock(reset4_word_clock),
	.ready(ready),
	.frame_sync(frame_sync),
	.miso(miso),
	.play_enable(play_enable),
	.start_addr(start_addr),
	.end_addr(end_addr)
);

// File: verif/pattern_gen_tb.sv
`include "pattern_gen_consts.svh"

module pattern_gen_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import pattern_gen_pkg::*;

	// spi half period and test clock half period, in word clocks
	localparam int half_period = 8;
	localparam int test_half_period = 7;
	localparam logic [7:0] cmd_read = 8'h02;
	// playback window, bytes 3 to 20 of the written words
	localparam int play_start = 3;
	localparam int play_end = 21;
	localparam int loop = play_end - play_start;

	logic word_clock;
	logic reset4_word_clock;
	logic sclk;
	logic mosi;
	logic ssel0;
	logic ssel1;
	logic test_clock;
	logic miso;
	logic ready;
	logic frame_sync;
	logic [7:0] sample_word;

	int errors;
	int passed;
	int failed;
	logic [31:0] wave_data [8];

	pattern_gen_top UUT (
		.word_clock(word_clock),
		.reset4_word_clock(reset4_word_clock),
		.sclk(sclk),
		.mosi(mosi),
		.ssel0(ssel0),
		.ssel1(ssel1),
		.test_clock(test_clock),
		.miso(miso),
		.ready(ready),
		.frame_sync(frame_sync),
		.sample_word(sample_word)
	);

	// ------------------------------------------------------------------------
	// clocks and run limit
	// ------------------------------------------------------------------------
	initial begin
		word_clock = 1'b0;
		forever #10 word_clock = ~word_clock;
	end

	// slow clock under measurement, period 14 word clocks
	initial begin
		test_clock <= 1'b0;
		forever begin
			repeat (test_half_period) @(posedge word_clock);
			test_clock <= ~test_clock;
		end
	end

	initial begin
		repeat (200000) @(posedge word_clock);
		$display("simulation stopped, the run exceeded its cycle limit");
		$display("Test FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	// own errors plus failed checker assertions
	function automatic int total_errors();
		return errors + UUT.chk.fail_count;
	endfunction

	// byte a of the waveform, msb of each word first
	function automatic logic [7:0] expected_byte(input int a);
		logic [31:0] w;
		w = wave_data[a / 4];
		return w[31 - 8 * (a % 4) -: 8];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] observed);
		assert (observed === expected)
		else begin
			$display("MISMATCH at %0t ns: %s expected %h observed %h",
				$time, name, expected, observed);
			errors++;
		end
	endtask

	// 1024 cycle gate over a 14 cycle period, one count of slack
	task automatic check_freq(input logic [31:0] observed);
		int expected;
		expected = (1 << `GATE_LOG2) / (2 * test_half_period);
		assert (observed >= expected - 1 && observed <= expected + 1)
		else begin
			$display("MISMATCH at %0t ns: freq_count expected %0d +-1 observed %0d",
				$time, expected, observed);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_at_start);
		if (total_errors() == errs_at_start) begin
			passed++;
			$display("test %-10s pass", name);
		end else begin
			failed++;
			$display("test %-10s fail, %0d new errors", name, total_errors() - errs_at_start);
		end
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (ready !== 1'b1 && cycles < 50) begin
			@(negedge word_clock);
			cycles++;
		end
		if (ready !== 1'b1) begin
			$display("timeout, ready never came up after reset");
			errors++;
		end
	endtask

	// returns on the negedge where frame_sync is high
	task automatic wait_sync();
		int cycles;
		cycles = 0;
		@(negedge word_clock);
		while (frame_sync !== 1'b1 && cycles < 200) begin
			@(negedge word_clock);
			cycles++;
		end
		if (frame_sync !== 1'b1) begin
			$display("timeout, no frame_sync with playback enabled");
			errors++;
		end
	endtask

	// ------------------------------------------------------------------------
	// spi host, mode 0, 56 bit frames
	// ------------------------------------------------------------------------
	task automatic spi_transfer(input logic sel, input logic [7:0] cmd,
		input logic [15:0] addr, input logic [31:0] wdata, output logic [31:0] rdata);
		logic [55:0] frame;
		frame = {cmd, addr, wdata};
		rdata = '0;
		@(posedge word_clock);
		if (sel)
			ssel1 <= 1'b0;
		else
			ssel0 <= 1'b0;
		repeat (half_period) @(posedge word_clock);
		for (int i = 55; i >= 0; i--) begin
			mosi <= frame[i];
			repeat (half_period) @(posedge word_clock);
			// data bits carry read data, sampled away from the clock edge
			@(negedge word_clock);
			if (i < 32)
				rdata = {rdata[30:0], miso};
			@(posedge word_clock);
			sclk <= 1'b1;
			repeat (half_period) @(posedge word_clock);
			sclk <= 1'b0;
		end
		repeat (half_period) @(posedge word_clock);
		ssel0 <= 1'b1;
		ssel1 <= 1'b1;
		// write pulse lands inside this gap
		repeat (half_period) @(posedge word_clock);
	endtask

	// random upper address bits, only the low nibble decodes
	task automatic write_reg(input reg_index_t idx, input logic [31:0] value);
		logic [31:0] unused;
		spi_transfer(1'b0, `CMD_WRITE, {12'($urandom), idx}, value, unused);
	endtask

	task automatic read_reg(input reg_index_t idx, output logic [31:0] value);
		spi_transfer(1'b0, cmd_read, {12'($urandom), idx}, 32'($urandom), value);
	endtask

	task automatic write_wave(input int index, input logic [31:0] value);
		logic [31:0] unused;
		spi_transfer(1'b1, `CMD_WRITE, 16'(index), value, unused);
	endtask

	task automatic read_wave(input int index, output logic [31:0] value);
		spi_transfer(1'b1, cmd_read, 16'(index), 32'($urandom), value);
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		int start_errs;
		logic [31:0] value;
		logic [31:0] observed;
		void'($urandom(32'h1948));
		errors = 0;
		passed = 0;
		failed = 0;
		reset4_word_clock <= 1'b1;
		sclk <= 1'b0;
		mosi <= 1'b0;
		ssel0 <= 1'b1;
		ssel1 <= 1'b1;

		// reset, checker watches the quiet outputs
		start_errs = total_errors();
		repeat (5) @(posedge word_clock);
		reset4_word_clock <= 1'b0;
		wait_ready();
		report_test("reset", start_errs);

		// register bank behind chip select 0
		start_errs = total_errors();
		value = $urandom;
		write_reg(`REG_START, value);
		read_reg(`REG_START, observed);
		compare_value("start_addr", value & ((32'd1 << `BYTE_ADDR_W) - 1), observed);
		value = $urandom;
		write_reg(`REG_END, value);
		read_reg(`REG_END, observed);
		compare_value("end_addr", value & ((32'd1 << `BYTE_ADDR_W) - 1), observed);
		// bit 0 kept clear, playback stays off
		value = $urandom & 32'hffff_fffe;
		write_reg(`REG_CONTROL, value);
		read_reg(`REG_CONTROL, observed);
		compare_value("control", value, observed);
		// freq still reads the measured count
		write_reg(`REG_FREQ, 32'($urandom));
		read_reg(`REG_FREQ, observed);
		check_freq(observed);
		write_reg(4'd5, 32'($urandom));
		read_reg(4'd5, observed);
		compare_value("unused reg 5", 32'd0, observed);
		read_reg(4'd9, observed);
		compare_value("unused reg 9", 32'd0, observed);
		report_test("registers", start_errs);

		// waveform words behind chip select 1
		start_errs = total_errors();
		for (int w = 0; w < 8; w++) begin
			wave_data[w] = $urandom;
			write_wave(w, wave_data[w]);
		end
		for (int w = 0; w < 8; w++) begin
			read_wave(w, observed);
			compare_value($sformatf("wave word %0d", w), wave_data[w], observed);
		end
		report_test("waveform", start_errs);

		// two full loops of playback
		start_errs = total_errors();
		write_reg(`REG_START, play_start);
		write_reg(`REG_END, play_end);
		write_reg(`REG_CONTROL, 32'd1);
		wait_sync();
		for (int k = 0; k < 2 * loop; k++) begin
			if (k > 0)
				@(negedge word_clock);
			compare_value("sample_word", expected_byte(play_start + k % loop), sample_word);
			compare_value("frame_sync", (k % loop) == 0, frame_sync);
		end
		report_test("playback", start_errs);

		// disabled, parked on the start byte
		start_errs = total_errors();
		write_reg(`REG_CONTROL, 32'd0);
		// drain the read path and sync pipeline
		repeat (4) @(posedge word_clock);
		for (int k = 0; k < 40; k++) begin
			@(negedge word_clock);
			compare_value("sample_word", expected_byte(play_start), sample_word);
			compare_value("frame_sync", 32'd0, frame_sync);
		end
		report_test("disabled", start_errs);

		// frequency count
		start_errs = total_errors();
		read_reg(`REG_FREQ, observed);
		check_freq(observed);
		report_test("frequency", start_errs);

		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			passed + failed, passed, failed, total_errors());
		if (failed == 0 && total_errors() == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
